/* list.f */
+incdir+include
rtl/mips_pkg.sv
rtl/reg_file.sv
rtl/stall_ctrl.sv
rtl/cpu_fetch.sv
rtl/cpu_decode.sv
rtl/cpu_execute.sv
rtl/cpu_result.sv
rtl/trivial_mips.sv
verif/tb_trivial_mips.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_trivial_mips
FILELIST  := list.f
OBJDIR    := obj_dir
PASS_MSG  := TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* verif/tb_trivial_mips.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module tb_trivial_mips;

localparam logic [31:0] MARKER_ADDR = 32'h0000_03fc;
localparam int TIMEOUT_CYCLES = 3000;

logic        clk;
logic        reset_i;
logic        inst_req_o;
logic [31:0] inst_addr_o;
logic [31:0] inst_rdata_i;
logic        inst_ready_i;
logic        data_req_o;
logic        data_we_o;
logic [31:0] data_addr_o;
logic [31:0] data_wdata_o;
logic [31:0] data_rdata_i;
logic        data_ready_i;

logic [31:0] imem [256];
logic [31:0] dmem [256];
logic [31:0] ref_dmem [256];
logic [31:0] exp_addr [$];
logic [31:0] exp_data [$];
logic [31:0] got_addr [$];
logic [31:0] got_data [$];
logic [7:0]  prog_len;
logic [15:0] lfsr_state;

int value_errs;
int other_errs;
logic done;

// Bus model state
logic        inst_active, inst_waiting, first_fetch_seen;
logic [1:0]  inst_wait;
logic [31:0] inst_addr_prev;
logic        data_active, data_waiting;
logic [1:0]  data_wait;
logic [31:0] data_addr_prev, data_wdata_prev;
logic        data_we_prev;
logic        store_seen;

trivial_mips uut (
	.clk,
	.reset_i,
	.inst_req_o,
	.inst_addr_o,
	.inst_rdata_i,
	.inst_ready_i,
	.data_req_o,
	.data_we_o,
	.data_addr_o,
	.data_wdata_o,
	.data_rdata_i,
	.data_ready_i
);

always #2 clk = ~clk;

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
endfunction

// Two random bits, one LFSR step each
function automatic logic [1:0] rand2();
	logic [1:0] v;
	v = 2'b00;
	lfsr_state = lfsr_next(lfsr_state);
	v = {v[0], lfsr_state[0]};
	lfsr_state = lfsr_next(lfsr_state);
	v = {v[0], lfsr_state[0]};
	return v;
endfunction

function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
	return {6'h00, rs, rt, rd, sh, funct};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

task automatic emit(input logic [31:0] word);
	imem[prog_len] = word;
	prog_len = prog_len + 8'd1;
endtask

// Instruction-level model with delay slots
function automatic void run_reference();
	logic [31:0] r [32];
	logic [31:0] hi, lo, pc, npc, nnpc, ins, a, b, sext, addr;
	longint p;
	int steps;
	logic stop;
	r = '{default: '0};
	hi = '0;
	lo = '0;
	pc = `MIPS_RESET_PC;
	npc = pc + 32'd4;
	stop = 1'b0;
	steps = 0;
	while (!stop && steps < 1000) begin
		ins = imem[pc[9:2]];
		a = r[ins[25:21]];
		b = r[ins[20:16]];
		sext = {{16{ins[15]}}, ins[15:0]};
		nnpc = npc + 32'd4;
		case (ins[31:26])
			6'h00: case (ins[5:0])
				6'h21: r[ins[15:11]] = a + b;
				6'h23: r[ins[15:11]] = a - b;
				6'h24: r[ins[15:11]] = a & b;
				6'h25: r[ins[15:11]] = a | b;
				6'h26: r[ins[15:11]] = a ^ b;
				6'h2a: r[ins[15:11]] = {31'b0, $signed(a) < $signed(b)};
				6'h00: r[ins[15:11]] = b << ins[10:6];
				6'h02: r[ins[15:11]] = b >> ins[10:6];
				6'h10: r[ins[15:11]] = hi;
				6'h12: r[ins[15:11]] = lo;
				6'h18: begin
					p = longint'($signed(a)) * longint'($signed(b));
					hi = p[63:32];
					lo = p[31:0];
				end
				default: ;
			endcase
			6'h09: r[ins[20:16]] = a + sext;
			6'h0d: r[ins[20:16]] = a | {16'h0, ins[15:0]};
			6'h0f: r[ins[20:16]] = {ins[15:0], 16'h0};
			6'h23: begin
				addr = a + sext;
				r[ins[20:16]] = ref_dmem[addr[9:2]];
			end
			6'h2b: begin
				addr = a + sext;
				ref_dmem[addr[9:2]] = b;
				exp_addr.push_back(addr);
				exp_data.push_back(b);
				stop = (addr == MARKER_ADDR);
			end
			6'h04: if (a == b) nnpc = npc + {sext[29:0], 2'b00};
			6'h05: if (a != b) nnpc = npc + {sext[29:0], 2'b00};
			default: ;
		endcase
		r[0] = '0;
		pc = npc;
		npc = nnpc;
		steps++;
	end
endfunction

task automatic load_program();
	prog_len = 8'd0;
	// ALU chain where each result feeds the next instruction
	emit(enc_i(6'h09, 5'd0, 5'd1, 16'h1234));
	emit(enc_i(6'h0f, 5'd0, 5'd2, 16'hdead));
	emit(enc_i(6'h0d, 5'd2, 5'd2, 16'hbeef));
	emit(enc_r(6'h21, 5'd1, 5'd2, 5'd3, 5'd0));
	emit(enc_r(6'h23, 5'd3, 5'd1, 5'd4, 5'd0));
	emit(enc_r(6'h24, 5'd4, 5'd2, 5'd5, 5'd0));
	emit(enc_r(6'h25, 5'd5, 5'd1, 5'd6, 5'd0));
	emit(enc_r(6'h26, 5'd6, 5'd3, 5'd7, 5'd0));
	emit(enc_r(6'h2a, 5'd7, 5'd1, 5'd8, 5'd0));
	emit(enc_r(6'h00, 5'd0, 5'd7, 5'd9, 5'd4));
	emit(enc_r(6'h02, 5'd0, 5'd7, 5'd10, 5'd3));
	for (logic [4:0] k = 5'd3; k <= 5'd10; k++)
		emit(enc_i(6'h2b, 5'd0, k, 16'h0200 + {9'b0, k - 5'd3, 2'b00}));
	// Signed multiply
	emit(enc_i(6'h09, 5'd0, 5'd11, 16'hfb2e));
	emit(enc_i(6'h0f, 5'd0, 5'd12, 16'h0001));
	emit(enc_i(6'h0d, 5'd12, 5'd12, 16'h2345));
	emit(enc_r(6'h18, 5'd11, 5'd12, 5'd0, 5'd0));
	emit(enc_r(6'h10, 5'd0, 5'd0, 5'd13, 5'd0));
	emit(enc_r(6'h12, 5'd0, 5'd0, 5'd14, 5'd0));
	emit(enc_i(6'h2b, 5'd0, 5'd13, 16'h0220));
	emit(enc_i(6'h2b, 5'd0, 5'd14, 16'h0224));
	// Loads and stores with the load result used at once
	emit(enc_i(6'h2b, 5'd0, 5'd2, 16'h0100));
	emit(enc_i(6'h23, 5'd0, 5'd15, 16'h0100));
	emit(enc_r(6'h21, 5'd15, 5'd1, 5'd16, 5'd0));
	emit(enc_i(6'h2b, 5'd0, 5'd16, 16'h0228));
	emit(enc_i(6'h23, 5'd0, 5'd17, 16'h0104));
	emit(enc_i(6'h2b, 5'd0, 5'd17, 16'h022c));
	emit(enc_i(6'h09, 5'd0, 5'd18, 16'h0108));
	emit(enc_i(6'h2b, 5'd18, 5'd7, 16'h0000));
	emit(enc_i(6'h23, 5'd18, 5'd19, 16'hfff8));
	emit(enc_i(6'h2b, 5'd18, 5'd19, 16'h0004));
	// Branches with delay slots
	emit(enc_i(6'h09, 5'd0, 5'd22, 16'h0055));
	emit(enc_i(6'h09, 5'd0, 5'd20, 16'h0001));
	emit(enc_i(6'h04, 5'd20, 5'd20, 16'h0002));
	emit(enc_i(6'h09, 5'd0, 5'd21, 16'h0011));
	emit(enc_i(6'h09, 5'd0, 5'd22, 16'h0077));
	emit(enc_i(6'h05, 5'd20, 5'd20, 16'h0002));
	emit(enc_i(6'h09, 5'd0, 5'd23, 16'h0022));
	emit(enc_i(6'h09, 5'd0, 5'd24, 16'h0033));
	emit(enc_i(6'h05, 5'd20, 5'd0, 16'h0002));
	emit(enc_i(6'h09, 5'd0, 5'd25, 16'h0044));
	emit(enc_i(6'h09, 5'd0, 5'd22, 16'h0066));
	for (logic [4:0] k = 5'd21; k <= 5'd25; k++)
		emit(enc_i(6'h2b, 5'd0, k, 16'h0230 + {9'b0, k - 5'd21, 2'b00}));
	emit(enc_i(6'h2b, 5'd0, 5'd20, MARKER_ADDR[15:0]));
endtask

// Instruction and data bus models with random wait states
always @(negedge clk) begin
	if (inst_waiting) begin
		assert (inst_req_o && inst_addr_o == inst_addr_prev) else begin
			$display("FAIL inst_addr_o: got %h expected %h", inst_addr_o, inst_addr_prev);
			value_errs++;
		end
	end
	if (data_waiting) begin
		assert (data_req_o && data_addr_o == data_addr_prev && data_we_o == data_we_prev
			&& (!data_we_o || data_wdata_o == data_wdata_prev)) else begin
			$display("FAIL data_addr_o/data_wdata_o: got %h/%h expected %h/%h",
				data_addr_o, data_wdata_o, data_addr_prev, data_wdata_prev);
			value_errs++;
		end
	end
	inst_waiting = 1'b0;
	data_waiting = 1'b0;
	inst_ready_i = 1'b0;
	data_ready_i = 1'b0;
	if (inst_req_o) begin
		if (!first_fetch_seen) begin
			first_fetch_seen = 1'b1;
			assert (inst_addr_o == `MIPS_RESET_PC) else begin
				$display("FAIL inst_addr_o: got %h expected %h", inst_addr_o, `MIPS_RESET_PC);
				value_errs++;
			end
		end
		if (!inst_active) begin
			inst_active = 1'b1;
			inst_wait = rand2();
		end
		if (inst_wait == 2'd0) begin
			inst_ready_i = 1'b1;
			inst_rdata_i = imem[inst_addr_o[9:2]];
			inst_active = 1'b0;
		end else begin
			inst_wait = inst_wait - 2'd1;
			inst_waiting = 1'b1;
			inst_addr_prev = inst_addr_o;
		end
	end
	if (data_req_o) begin
		if (!data_active) begin
			// First data access of the program is a store
			assert (data_we_o || store_seen) else begin
				$display("Data read requested before the first store");
				other_errs++;
			end
			data_active = 1'b1;
			data_wait = rand2();
		end
		if (data_wait == 2'd0) begin
			data_ready_i = 1'b1;
			data_active = 1'b0;
			if (data_we_o) begin
				store_seen = 1'b1;
				dmem[data_addr_o[9:2]] = data_wdata_o;
				got_addr.push_back(data_addr_o);
				got_data.push_back(data_wdata_o);
			end else begin
				data_rdata_i = dmem[data_addr_o[9:2]];
			end
		end else begin
			data_wait = data_wait - 2'd1;
			data_waiting = 1'b1;
			data_addr_prev = data_addr_o;
			data_wdata_prev = data_wdata_o;
			data_we_prev = data_we_o;
		end
	end
end

// Store checker
always @(posedge clk) begin
	while (got_addr.size() > 0) begin
		if (exp_addr.size() == 0) begin
			$display("Store to %h seen after the last expected store", got_addr[0]);
			other_errs++;
		end else begin
			assert (got_addr[0] == exp_addr[0]) else begin
				$display("FAIL data_addr_o: got %h expected %h", got_addr[0], exp_addr[0]);
				value_errs++;
			end
			assert (got_data[0] == exp_data[0]) else begin
				$display("FAIL data_wdata_o: got %h expected %h", got_data[0], exp_data[0]);
				value_errs++;
			end
			void'(exp_addr.pop_front());
			void'(exp_data.pop_front());
		end
		if (got_addr[0] == MARKER_ADDR)
			done = 1'b1;
		void'(got_addr.pop_front());
		void'(got_data.pop_front());
	end
end

initial begin
	int cycles;
	clk = 1'b0;
	reset_i = 1'b1;
	inst_rdata_i = '0;
	inst_ready_i = 1'b0;
	data_rdata_i = '0;
	data_ready_i = 1'b0;
	lfsr_state = 16'd81;
	value_errs = 0;
	other_errs = 0;
	done = 1'b0;
	inst_active = 1'b0;
	inst_waiting = 1'b0;
	inst_wait = 2'd0;
	inst_addr_prev = '0;
	first_fetch_seen = 1'b0;
	data_active = 1'b0;
	data_waiting = 1'b0;
	data_wait = 2'd0;
	data_addr_prev = '0;
	data_wdata_prev = '0;
	data_we_prev = 1'b0;
	store_seen = 1'b0;
	imem = '{default: '0};
	for (int i = 0; i < 256; i++)
		dmem[i] = 32'hd000_0000 | {22'b0, i[7:0], 2'b00};
	ref_dmem = dmem;
	load_program();
	run_reference();

	repeat (3) begin
		@(negedge clk);
		assert (!inst_req_o && !data_req_o) else begin
			$display("Request raised while reset is active");
			other_errs++;
		end
	end
	reset_i = 1'b0;

	cycles = 0;
	while (!done && cycles < TIMEOUT_CYCLES) begin
		@(negedge clk);
		cycles++;
	end
	if (!done) begin
		$display("Timed out waiting for the marker store");
		other_errs++;
	end else begin
		for (int i = 0; i < 256; i++) begin
			assert (dmem[i] == ref_dmem[i]) else begin
				$display("FAIL dmem[%h]: got %h expected %h", i[7:0], dmem[i], ref_dmem[i]);
				value_errs++;
			end
		end
		if (exp_addr.size() != 0) begin
			$display("Expected stores are missing");
			other_errs++;
		end
	end

	$display("Errors: value %0d, other %0d", value_errs, other_errs);
	if (value_errs == 0 && other_errs == 0) begin
		$display("TB PASSED");
	end else begin
		$display("TB FAILED");
	end
	$finish;
end

endmodule

/* rtl/trivial_mips.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module trivial_mips (
	input  logic                  clk,
	input  logic                  reset_i,
	output logic                  inst_req_o,
	output logic [`MIPS_XLEN-1:0] inst_addr_o,
	input  logic [`MIPS_XLEN-1:0] inst_rdata_i,
	input  logic                  inst_ready_i,
	output logic                  data_req_o,
	output logic                  data_we_o,
	output logic [`MIPS_XLEN-1:0] data_addr_o,
	output logic [`MIPS_XLEN-1:0] data_wdata_o,
	input  logic [`MIPS_XLEN-1:0] data_rdata_i,
	input  logic                  data_ready_i
);

mips_pkg::stall_t stall;
logic fetch_stall;
logic mem_stall;

// Fetch to decode
mips_pkg::inst_t       id_inst;
logic [`MIPS_XLEN-1:0] id_pc;
logic                  id_valid;
logic                  branch_taken;
logic [`MIPS_XLEN-1:0] branch_target;

// Register file ports
logic [`MIPS_REG_AW-1:0] raddr1, raddr2;
logic [`MIPS_XLEN-1:0]   rdata1, rdata2;
logic                    rf_we;
logic [`MIPS_REG_AW-1:0] rf_waddr;
logic [`MIPS_XLEN-1:0]   rf_wdata;

// Decode to execute
mips_pkg::oper_t         ex_op;
logic [`MIPS_XLEN-1:0]   ex_a, ex_b, ex_store_data;
logic [`MIPS_REG_AW-1:0] ex_dest;

// Execute forwarding and result stage request
logic                    ex_wr_en, wb_wr_en;
logic [`MIPS_REG_AW-1:0] ex_wr_addr, wb_wr_addr;
logic [`MIPS_XLEN-1:0]   ex_wr_data, wb_wr_data;

stall_ctrl stall_ctrl_inst (
	.fetch_stall_i(fetch_stall),
	.mem_stall_i  (mem_stall),
	.stall_o      (stall)
);

cpu_fetch fetch_inst (
	.clk,
	.reset_i,
	.stall_i        (stall),
	.branch_taken_i (branch_taken),
	.branch_target_i(branch_target),
	.inst_req_o,
	.inst_addr_o,
	.inst_rdata_i,
	.inst_ready_i,
	.fetch_stall_o  (fetch_stall),
	.id_inst_o      (id_inst),
	.id_pc_o        (id_pc),
	.id_valid_o     (id_valid)
);

reg_file reg_file_inst (
	.clk,
	.reset_i,
	.we_i    (rf_we),
	.waddr_i (rf_waddr),
	.wdata_i (rf_wdata),
	.raddr1_i(raddr1),
	.raddr2_i(raddr2),
	.rdata1_o(rdata1),
	.rdata2_o(rdata2)
);

// Result write port doubles as the second forwarding source
cpu_decode decode_inst (
	.clk,
	.reset_i,
	.stall_i        (stall),
	.id_inst_i      (id_inst),
	.id_pc_i        (id_pc),
	.id_valid_i     (id_valid),
	.raddr1_o       (raddr1),
	.raddr2_o       (raddr2),
	.rdata1_i       (rdata1),
	.rdata2_i       (rdata2),
	.ex_wr_en_i     (ex_wr_en),
	.ex_wr_addr_i   (ex_wr_addr),
	.ex_wr_data_i   (ex_wr_data),
	.wb_wr_en_i     (rf_we),
	.wb_wr_addr_i   (rf_waddr),
	.wb_wr_data_i   (rf_wdata),
	.branch_taken_o (branch_taken),
	.branch_target_o(branch_target),
	.ex_op_o        (ex_op),
	.ex_a_o         (ex_a),
	.ex_b_o         (ex_b),
	.ex_store_data_o(ex_store_data),
	.ex_dest_o      (ex_dest)
);

cpu_execute execute_inst (
	.clk,
	.reset_i,
	.stall_i        (stall),
	.ex_op_i        (ex_op),
	.ex_a_i         (ex_a),
	.ex_b_i         (ex_b),
	.ex_store_data_i(ex_store_data),
	.ex_dest_i      (ex_dest),
	.data_req_o,
	.data_we_o,
	.data_addr_o,
	.data_wdata_o,
	.data_rdata_i,
	.data_ready_i,
	.mem_stall_o    (mem_stall),
	.ex_wr_en_o     (ex_wr_en),
	.ex_wr_addr_o   (ex_wr_addr),
	.ex_wr_data_o   (ex_wr_data),
	.wb_wr_en_o     (wb_wr_en),
	.wb_wr_addr_o   (wb_wr_addr),
	.wb_wr_data_o   (wb_wr_data)
);

cpu_result result_inst (
	.clk,
	.reset_i,
	.stall_i     (stall),
	.wb_wr_en_i  (wb_wr_en),
	.wb_wr_addr_i(wb_wr_addr),
	.wb_wr_data_i(wb_wr_data),
	.rf_we_o     (rf_we),
	.rf_waddr_o  (rf_waddr),
	.rf_wdata_o  (rf_wdata)
);

endmodule

/* rtl/cpu_result.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module cpu_result (
	input  logic                    clk,
	input  logic                    reset_i,
	input  mips_pkg::stall_t        stall_i,
	input  logic                    wb_wr_en_i,
	input  logic [`MIPS_REG_AW-1:0] wb_wr_addr_i,
	input  logic [`MIPS_XLEN-1:0]   wb_wr_data_i,
	output logic                    rf_we_o,
	output logic [`MIPS_REG_AW-1:0] rf_waddr_o,
	output logic [`MIPS_XLEN-1:0]   rf_wdata_o
);

// Writes to r0 are dropped here
always_ff @(posedge clk) begin
	if (reset_i)
		rf_we_o <= 1'b0;
	else
		rf_we_o <= wb_wr_en_i && !stall_i.bubble_result && wb_wr_addr_i != '0;
end

always_ff @(posedge clk) begin
	rf_waddr_o <= wb_wr_addr_i;
	rf_wdata_o <= wb_wr_data_i;
end

// A bubble while execute moves on would lose an instruction
a_bubble_with_hold: assert property (@(posedge clk) disable iff (reset_i)
	stall_i.bubble_result |-> stall_i.hold_execute);

endmodule

/* rtl/cpu_execute.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module cpu_execute (
	input  logic                    clk,
	input  logic                    reset_i,
	input  mips_pkg::stall_t        stall_i,
	input  mips_pkg::oper_t         ex_op_i,
	input  logic [`MIPS_XLEN-1:0]   ex_a_i,
	input  logic [`MIPS_XLEN-1:0]   ex_b_i,
	input  logic [`MIPS_XLEN-1:0]   ex_store_data_i,
	input  logic [`MIPS_REG_AW-1:0] ex_dest_i,
	output logic                    data_req_o,
	output logic                    data_we_o,
	output logic [`MIPS_XLEN-1:0]   data_addr_o,
	output logic [`MIPS_XLEN-1:0]   data_wdata_o,
	input  logic [`MIPS_XLEN-1:0]   data_rdata_i,
	input  logic                    data_ready_i,
	output logic                    mem_stall_o,
	output logic                    ex_wr_en_o,
	output logic [`MIPS_REG_AW-1:0] ex_wr_addr_o,
	output logic [`MIPS_XLEN-1:0]   ex_wr_data_o,
	output logic                    wb_wr_en_o,
	output logic [`MIPS_REG_AW-1:0] wb_wr_addr_o,
	output logic [`MIPS_XLEN-1:0]   wb_wr_data_o
);

logic [`MIPS_XLEN-1:0]   hi;
logic [`MIPS_XLEN-1:0]   lo;
logic [`MIPS_XLEN-1:0]   sum;
logic [`MIPS_XLEN-1:0]   result;
logic [2*`MIPS_XLEN-1:0] product;
logic                    wr_en;

// Shared adder for addu and the load/store address
assign sum     = ex_a_i + ex_b_i;
assign product = $signed(ex_a_i) * $signed(ex_b_i);

always_comb begin
	case (ex_op_i)
		mips_pkg::OP_ADDU: result = sum;
		mips_pkg::OP_SUBU: result = ex_a_i - ex_b_i;
		mips_pkg::OP_AND:  result = ex_a_i & ex_b_i;
		mips_pkg::OP_OR:   result = ex_a_i | ex_b_i;
		mips_pkg::OP_XOR:  result = ex_a_i ^ ex_b_i;
		mips_pkg::OP_SLT:  result = {31'b0, $signed(ex_a_i) < $signed(ex_b_i)};
		mips_pkg::OP_SLL:  result = ex_a_i << ex_b_i[4:0];
		mips_pkg::OP_SRL:  result = ex_a_i >> ex_b_i[4:0];
		mips_pkg::OP_MFHI: result = hi;
		mips_pkg::OP_MFLO: result = lo;
		mips_pkg::OP_LW:   result = data_rdata_i;
		default:           result = '0;
	endcase
end

assign wr_en = !(ex_op_i inside {mips_pkg::OP_NOP, mips_pkg::OP_SW, mips_pkg::OP_MULT});

// Data bus, held stable by the stall until ready
assign data_req_o   = (ex_op_i == mips_pkg::OP_LW) || (ex_op_i == mips_pkg::OP_SW);
assign data_we_o    = (ex_op_i == mips_pkg::OP_SW);
assign data_addr_o  = sum;
assign data_wdata_o = ex_store_data_i;
assign mem_stall_o  = data_req_o & ~data_ready_i;

assign ex_wr_en_o   = wr_en;
assign ex_wr_addr_o = ex_dest_i;
assign ex_wr_data_o = result;

// Only a finished operation goes on to the result stage
assign wb_wr_en_o   = wr_en & ~mem_stall_o;
assign wb_wr_addr_o = ex_dest_i;
assign wb_wr_data_o = result;

always_ff @(posedge clk) begin
	if (reset_i) begin
		hi <= '0;
		lo <= '0;
	end else if (ex_op_i == mips_pkg::OP_MULT && !stall_i.hold_execute) begin
		hi <= product[2*`MIPS_XLEN-1:`MIPS_XLEN];
		lo <= product[`MIPS_XLEN-1:0];
	end
end

a_data_aligned: assert property (@(posedge clk) disable iff (reset_i)
	data_req_o |-> data_addr_o[1:0] == 2'b00);

endmodule

/* rtl/cpu_decode.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module cpu_decode (
	input  logic                    clk,
	input  logic                    reset_i,
	input  mips_pkg::stall_t        stall_i,
	input  mips_pkg::inst_t         id_inst_i,
	input  logic [`MIPS_XLEN-1:0]   id_pc_i,
	input  logic                    id_valid_i,
	output logic [`MIPS_REG_AW-1:0] raddr1_o,
	output logic [`MIPS_REG_AW-1:0] raddr2_o,
	input  logic [`MIPS_XLEN-1:0]   rdata1_i,
	input  logic [`MIPS_XLEN-1:0]   rdata2_i,
	input  logic                    ex_wr_en_i,
	input  logic [`MIPS_REG_AW-1:0] ex_wr_addr_i,
	input  logic [`MIPS_XLEN-1:0]   ex_wr_data_i,
	input  logic                    wb_wr_en_i,
	input  logic [`MIPS_REG_AW-1:0] wb_wr_addr_i,
	input  logic [`MIPS_XLEN-1:0]   wb_wr_data_i,
	output logic                    branch_taken_o,
	output logic [`MIPS_XLEN-1:0]   branch_target_o,
	output mips_pkg::oper_t         ex_op_o,
	output logic [`MIPS_XLEN-1:0]   ex_a_o,
	output logic [`MIPS_XLEN-1:0]   ex_b_o,
	output logic [`MIPS_XLEN-1:0]   ex_store_data_o,
	output logic [`MIPS_REG_AW-1:0] ex_dest_o
);

logic [`MIPS_XLEN-1:0]   rs_val;
logic [`MIPS_XLEN-1:0]   rt_val;
logic [`MIPS_XLEN-1:0]   sext_imm;
logic [`MIPS_XLEN-1:0]   a;
logic [`MIPS_XLEN-1:0]   b;
logic [`MIPS_REG_AW-1:0] dest;
mips_pkg::oper_t         op;

// Youngest producer wins: execute first, then result
function automatic logic [`MIPS_XLEN-1:0] forward(input logic [`MIPS_REG_AW-1:0] addr,
		input logic [`MIPS_XLEN-1:0] rf_data);
	if (addr != '0 && ex_wr_en_i && ex_wr_addr_i == addr)
		return ex_wr_data_i;
	if (addr != '0 && wb_wr_en_i && wb_wr_addr_i == addr)
		return wb_wr_data_i;
	return rf_data;
endfunction

assign raddr1_o = id_inst_i.r.rs;
assign raddr2_o = id_inst_i.r.rt;
assign sext_imm = {{16{id_inst_i.i.imm16[15]}}, id_inst_i.i.imm16};

always_comb begin
	rs_val = forward(id_inst_i.r.rs, rdata1_i);
	rt_val = forward(id_inst_i.r.rt, rdata2_i);
end

// beq / bne resolved here, target relative to the delay slot
assign branch_target_o = id_pc_i + 32'd4 + {sext_imm[29:0], 2'b00};
assign branch_taken_o  = id_valid_i &&
	((id_inst_i.i.opcode == 6'h04 && rs_val == rt_val) ||
	 (id_inst_i.i.opcode == 6'h05 && rs_val != rt_val));

always_comb begin
	op   = mips_pkg::OP_NOP;
	a    = rs_val;
	b    = rt_val;
	dest = '0;
	case (id_inst_i.r.opcode)
		6'h00: begin
			dest = id_inst_i.r.rd;
			case (id_inst_i.r.funct)
				6'h21: op = mips_pkg::OP_ADDU;
				6'h23: op = mips_pkg::OP_SUBU;
				6'h24: op = mips_pkg::OP_AND;
				6'h25: op = mips_pkg::OP_OR;
				6'h26: op = mips_pkg::OP_XOR;
				6'h2a: op = mips_pkg::OP_SLT;
				6'h18: op = mips_pkg::OP_MULT;
				6'h10: op = mips_pkg::OP_MFHI;
				6'h12: op = mips_pkg::OP_MFLO;
				6'h00, 6'h02: begin
					// Shifts take rt as the value and shamt as the amount
					op = (id_inst_i.r.funct == 6'h00) ? mips_pkg::OP_SLL : mips_pkg::OP_SRL;
					a  = rt_val;
					b  = {27'b0, id_inst_i.r.shamt};
				end
				default: dest = '0;
			endcase
		end
		6'h09: begin
			op   = mips_pkg::OP_ADDU;
			b    = sext_imm;
			dest = id_inst_i.i.rt;
		end
		6'h0d, 6'h0f: begin
			// lui is an or of zero with the shifted immediate
			op   = mips_pkg::OP_OR;
			a    = (id_inst_i.i.opcode == 6'h0f) ? '0 : rs_val;
			b    = (id_inst_i.i.opcode == 6'h0f) ? {id_inst_i.i.imm16, 16'h0}
				: {16'h0, id_inst_i.i.imm16};
			dest = id_inst_i.i.rt;
		end
		6'h23: begin
			op   = mips_pkg::OP_LW;
			b    = sext_imm;
			dest = id_inst_i.i.rt;
		end
		6'h2b: begin
			op = mips_pkg::OP_SW;
			b  = sext_imm;
		end
		default: op = mips_pkg::OP_NOP;
	endcase
end

always_ff @(posedge clk) begin
	if (reset_i) begin
		ex_op_o   <= mips_pkg::OP_NOP;
		ex_dest_o <= '0;
	end else if (!stall_i.hold_execute) begin
		ex_op_o   <= id_valid_i ? op : mips_pkg::OP_NOP;
		ex_dest_o <= id_valid_i ? dest : '0;
	end
end

always_ff @(posedge clk) begin
	if (!stall_i.hold_execute) begin
		ex_a_o          <= a;
		ex_b_o          <= b;
		ex_store_data_o <= rt_val;
	end
end

endmodule

/* rtl/cpu_fetch.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module cpu_fetch (
	input  logic                  clk,
	input  logic                  reset_i,
	input  mips_pkg::stall_t      stall_i,
	input  logic                  branch_taken_i,
	input  logic [`MIPS_XLEN-1:0] branch_target_i,
	output logic                  inst_req_o,
	output logic [`MIPS_XLEN-1:0] inst_addr_o,
	input  logic [`MIPS_XLEN-1:0] inst_rdata_i,
	input  logic                  inst_ready_i,
	output logic                  fetch_stall_o,
	output mips_pkg::inst_t       id_inst_o,
	output logic [`MIPS_XLEN-1:0] id_pc_o,
	output logic                  id_valid_o
);

logic [`MIPS_XLEN-1:0] pc;
logic [`MIPS_XLEN-1:0] redir_pc;
logic [`MIPS_XLEN-1:0] pend_pc;
mips_pkg::inst_t       pend_inst;
logic                  started;
logic                  redir_q;
logic                  pend_valid;
logic                  accept;

// No new request while a held instruction waits in the skid register
assign inst_req_o    = started & ~pend_valid;
assign inst_addr_o   = pc;
assign accept        = inst_req_o & inst_ready_i;
assign fetch_stall_o = ~pend_valid & ~accept;

always_ff @(posedge clk) begin
	if (reset_i) begin
		started <= 1'b0;
		pc      <= `MIPS_RESET_PC;
		redir_q <= 1'b0;
	end else begin
		started <= 1'b1;
		if (accept) begin
			// The accepted word is the delay slot when a redirect is due
			if (redir_q)
				pc <= redir_pc;
			else if (branch_taken_i && !stall_i.hold_decode)
				pc <= branch_target_i;
			else
				pc <= pc + 32'd4;
			redir_q <= 1'b0;
		end else if (branch_taken_i && !stall_i.hold_decode) begin
			// Branch leaves decode without a delay slot accepted this cycle
			if (pend_valid)
				pc <= branch_target_i;
			else
				redir_q <= 1'b1;
		end
	end
end

always_ff @(posedge clk) begin
	if (branch_taken_i)
		redir_pc <= branch_target_i;
end

always_ff @(posedge clk) begin
	if (reset_i) begin
		id_valid_o <= 1'b0;
		pend_valid <= 1'b0;
	end else if (!stall_i.hold_decode) begin
		pend_valid <= 1'b0;
		id_valid_o <= pend_valid | ~stall_i.hold_fetch;
	end else if (accept) begin
		pend_valid <= 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (!stall_i.hold_decode) begin
		id_inst_o <= pend_valid ? pend_inst : inst_rdata_i;
		id_pc_o   <= pend_valid ? pend_pc : pc;
	end else if (accept) begin
		pend_inst <= inst_rdata_i;
		pend_pc   <= pc;
	end
end

a_inst_addr_stable: assert property (@(posedge clk) disable iff (reset_i)
	inst_req_o && !inst_ready_i |=> inst_req_o && $stable(inst_addr_o));

endmodule

/* rtl/stall_ctrl.sv */
`timescale 1ns/1ps

module stall_ctrl (
	input  logic             fetch_stall_i,
	input  logic             mem_stall_i,
	output mips_pkg::stall_t stall_o
);

always_comb begin
	stall_o = '0;
	if (mem_stall_i) begin
		// Data stall freezes everything younger than result
		stall_o.hold_fetch    = 1'b1;
		stall_o.hold_decode   = 1'b1;
		stall_o.hold_execute  = 1'b1;
		stall_o.bubble_result = 1'b1;
	end else if (fetch_stall_i) begin
		// Older instructions drain, decode sees a NOP
		stall_o.hold_fetch = 1'b1;
	end
end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module reg_file (
	input  logic                    clk,
	input  logic                    reset_i,
	input  logic                    we_i,
	input  logic [`MIPS_REG_AW-1:0] waddr_i,
	input  logic [`MIPS_XLEN-1:0]   wdata_i,
	input  logic [`MIPS_REG_AW-1:0] raddr1_i,
	input  logic [`MIPS_REG_AW-1:0] raddr2_i,
	output logic [`MIPS_XLEN-1:0]   rdata1_o,
	output logic [`MIPS_XLEN-1:0]   rdata2_o
);

logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_NUM];

// r0 reads zero, a same-cycle write is passed through
function automatic logic [`MIPS_XLEN-1:0] read_port(input logic [`MIPS_REG_AW-1:0] addr);
	if (addr == '0)
		return '0;
	if (we_i && waddr_i == addr)
		return wdata_i;
	return regs[addr];
endfunction

always_comb begin
	rdata1_o = read_port(raddr1_i);
	rdata2_o = read_port(raddr2_i);
end

always_ff @(posedge clk) begin
	if (reset_i) begin
		for (int i = 0; i < `MIPS_REG_NUM; i++)
			regs[i] <= '0;
	end else if (we_i && waddr_i != '0) begin
		regs[waddr_i] <= wdata_i;
	end
end

endmodule

/* rtl/mips_pkg.sv */
package mips_pkg;

// R-type view: register operands and function code
typedef struct packed {
	logic [5:0] opcode;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;
	logic [4:0] shamt;
	logic [5:0] funct;
} r_inst_t;

// I-type view: 16-bit immediate in the low half
typedef struct packed {
	logic [5:0]  opcode;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [15:0] imm16;
} i_inst_t;

typedef union packed {
	r_inst_t r;
	i_inst_t i;
} inst_t;

// Operations carried from decode into execute
typedef enum logic [3:0] {
	OP_NOP,
	OP_ADDU,
	OP_SUBU,
	OP_AND,
	OP_OR,
	OP_XOR,
	OP_SLT,
	OP_SLL,
	OP_SRL,
	OP_MULT,
	OP_MFHI,
	OP_MFLO,
	OP_LW,
	OP_SW
} oper_t;

typedef struct packed {
	logic hold_fetch;
	logic hold_decode;
	logic hold_execute;
	logic bubble_result;
} stall_t;

endpackage

/* include/mips_params.svh */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// First instruction address after reset
`define MIPS_RESET_PC 32'h0000_0000

// Data path width
`define MIPS_XLEN 32

// General register address width
`define MIPS_REG_AW 5

// Number of general registers, r0 included
`define MIPS_REG_NUM 32

`endif
